//--- src/dmm_pkg.sv
/*
  shared definitions for the meter control FPGA
  register map, conditioning vector bit layout, mode codes, SPI frame sizes
  every RTL file takes this in with a wildcard import in its module header
*/

package dmm_pkg;

  ////////////////////
  // widths

  localparam int cmd_bits  = 8;    // read flag + 7 bit address
  localparam int data_bits = 32;
  localparam int cond_bits = 29;   // 4x4 mux + pc + led + 8 mon + 3 singles

  typedef logic [data_bits-1:0]  reg_word_t;
  typedef logic [cmd_bits-2:0]   reg_addr_t;   // cmd byte minus read flag
  typedef logic [cond_bits-1:0]  cond_vec_t;

  // mode register, only low three bits are stored
  // codes 4..7 were the modulation sequencers, now just park everything low
  typedef enum logic [2:0] {
    mode_led     = 3'd0,   // fpga idle, led under mcu control
    mode_ones    = 3'd1,   // every conditioning pin high
    mode_pattern = 3'd2,   // free running counter on the pins
    mode_direct  = 3'd3    // pins straight from the direct register
  } mode_t;

  ////////////////////
  // register addresses

  localparam reg_addr_t addr_led     = 7'd0;
  localparam reg_addr_t addr_oe_4094 = 7'd1;
  localparam reg_addr_t addr_mode    = 7'd2;
  localparam reg_addr_t addr_direct  = 7'd3;
  localparam reg_addr_t addr_status  = 7'd4;   // read only

  ////////////////////
  // conditioning vector layout
  // these are base indices, wide fields are taken with +:

  localparam int idx_azmux         = 0;    // u414 a0..a2, en
  localparam int idx_himux         = 4;    // u413
  localparam int idx_himux2        = 8;    // u402
  localparam int idx_sig_pc_sw     = 12;   // pre-charge switch
  localparam int idx_led0          = 13;
  localparam int idx_monitor       = 14;   // 8 pins, 14..21
  localparam int idx_adcmux        = 22;   // u902 current switches
  localparam int idx_cmpr_latch    = 26;
  localparam int idx_meas_complete = 27;
  localparam int idx_spi_interupt  = 28;   // top bit

  // 4094 strobe level while the chain is selected
  localparam logic strobe_active_high = 1'b1;

endpackage

//--- src/reg_bus_if.sv
/*
  register bus between the SPI slave and the register bank
  wr and rd are single clk strobes with addr valid alongside, no acknowledge
  rdata is combinational from addr
*/

interface reg_bus_if
  import dmm_pkg::*;
;

  logic      wr;      // write strobe, wdata taken this cycle
  reg_addr_t addr;    // valid whenever wr or rd is high
  reg_word_t wdata;
  logic      rd;      // read strobe, rdata sampled this cycle
  reg_word_t rdata;   // from the bank read mux

  // spi side
  modport master (
    output wr,
    output addr,
    output wdata,
    output rd,
    input  rdata
  );

  // register side
  modport slave (
    input  wr,
    input  addr,
    input  wdata,
    input  rd,
    output rdata
  );

endinterface

//--- src/spi_slave.sv
/*
  SPI mode 0 slave with the pins oversampled in the clk domain
  40 bit frame of a command byte (read flag and 7 bit address) then 32 data bits
  reads fetch rdata after the command byte and writes commit at chip select release
*/

module spi_slave
  import dmm_pkg::*;
#(
  parameter int sync_stages = 2    // 2 or 3 flops per pin
)
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      spi_clk,
  input  logic      spi_cs,
  input  logic      spi_mosi,
  output logic      sdo,           // read data toward miso
  reg_bus_if.master bus
);

  localparam int frame_bits = cmd_bits + data_bits;
  localparam int cnt_w      = $clog2(frame_bits + 1) + 1;   // headroom for long frames

  ////////////////////
  // synchronisers

  logic [sync_stages-1:0] sclk_sync;
  logic [sync_stages-1:0] cs_sync;
  logic [sync_stages-1:0] mosi_sync;
  logic                   sclk_d;    // one more stage for edge detect
  logic                   cs_d;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sclk_sync <= '0;
      cs_sync   <= '1;      // cs idles high so no fake frame start
      mosi_sync <= '0;
      sclk_d    <= 1'b0;
      cs_d      <= 1'b1;
    end
    else
    begin
      sclk_sync <= {sclk_sync[sync_stages-2:0], spi_clk};
      cs_sync   <= {cs_sync[sync_stages-2:0], spi_cs};
      mosi_sync <= {mosi_sync[sync_stages-2:0], spi_mosi};
      sclk_d    <= sclk_sync[sync_stages-1];
      cs_d      <= cs_sync[sync_stages-1];
    end
  end

  // mosi goes through the same depth as sclk so it lines up with the rising edge
  wire sclk_s  = sclk_sync[sync_stages-1];
  wire cs_s    = cs_sync[sync_stages-1];
  wire mosi_s  = mosi_sync[sync_stages-1];

  wire sclk_rise = sclk_s & ~sclk_d & ~cs_s;   // only inside a frame
  wire sclk_fall = ~sclk_s & sclk_d & ~cs_s;
  wire cs_fall   = ~cs_s & cs_d;               // frame start
  wire cs_rise   = cs_s & ~cs_d;               // frame end

  ////////////////////
  // shift in and command decode

  logic [cnt_w-1:0]    bit_cnt;    // saturates so overlong frames never match
  logic [cmd_bits-1:0] cmd_q;      // read flag on top of the 7 bit address
  reg_word_t           shift_in;
  logic                wr_q;
  logic                rd_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt <= '0;
      cmd_q   <= '0;
      wr_q    <= 1'b0;
      rd_q    <= 1'b0;
    end
    else
    begin
      wr_q <= 1'b0;    // strobes default low
      rd_q <= 1'b0;

      if (cs_s)
        bit_cnt <= '0;
      else if (sclk_rise)
      begin
        if (bit_cnt != '1)
          bit_cnt <= bit_cnt + 1'b1;
        // eighth bit closes the command byte
        if (bit_cnt == cnt_w'(cmd_bits - 1))
        begin
          cmd_q <= {shift_in[cmd_bits-2:0], mosi_s};
          rd_q  <= shift_in[cmd_bits-2];   // first bit in is the read flag
        end
      end

      // commit only full length write frames
      if (cs_rise && bit_cnt == cnt_w'(frame_bits) && !cmd_q[cmd_bits-1])
        wr_q <= 1'b1;
    end
  end

  // command and data bits shift in here
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      shift_in <= '0;
    else if (sclk_rise)
      shift_in <= {shift_in[data_bits-2:0], mosi_s};   // msb first
  end

  ////////////////////
  // shift out

  reg_word_t shift_out;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shift_out <= '0;
      sdo       <= 1'b0;
    end
    else if (cs_fall)
    begin
      shift_out <= '0;     // write frames clock out zeros
      sdo       <= 1'b0;
    end
    else if (rd_q)
      shift_out <= bus.rdata;          // loaded before the next falling edge
    else if (sclk_fall)
    begin
      sdo       <= shift_out[data_bits-1];
      shift_out <= {shift_out[data_bits-2:0], 1'b0};
    end
  end

  assign bus.wr    = wr_q;
  assign bus.rd    = rd_q;
  assign bus.addr  = cmd_q[cmd_bits-2:0];
  assign bus.wdata = shift_in;   // stable once cs is high

endmodule

//--- src/register_bank.sv
/*
  control and status registers on the clk domain register bus
  led, 4094 output enable, mode, direct field, plus a read only status word
  unused addresses read zero and swallow writes
*/

module register_bank
  import dmm_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  reg_bus_if.slave      bus,
  input  logic [4:0]    status_in,    // switch, dcv ovp, ohms ovp, supply, unused_2
  output logic          reg_led,
  output mode_t         reg_mode,
  output cond_vec_t     reg_direct,
  output logic          oe_4094_ctl
);

  ////////////////////
  // write side

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      reg_led     <= 1'b0;
      oe_4094_ctl <= 1'b0;    // chain outputs off until mcu checks supplies
      reg_mode    <= mode_led;
      reg_direct  <= '0;
    end
    else if (bus.wr)
    begin
      case (bus.addr)
        addr_led:     reg_led     <= bus.wdata[0];
        addr_oe_4094: oe_4094_ctl <= bus.wdata[0];
        addr_mode:    reg_mode    <= mode_t'(bus.wdata[2:0]);   // 4..7 kept as is
        addr_direct:  reg_direct  <= bus.wdata[cond_bits-1:0];
        default:      ;   // status and unmapped, ignore
      endcase
    end
  end

  ////////////////////
  // read mux
  // combinational from addr, slave samples it on rd

  always_comb
  begin
    bus.rdata = '0;
    case (bus.addr)
      addr_led:
        bus.rdata = {{(data_bits-1){1'b0}}, reg_led};
      addr_oe_4094:
        bus.rdata = {{(data_bits-1){1'b0}}, oe_4094_ctl};
      addr_mode:
        bus.rdata = {{(data_bits-3){1'b0}}, reg_mode};
      addr_direct:
        bus.rdata = {{(data_bits-cond_bits){1'b0}}, reg_direct};
      addr_status:
        bus.rdata = {{(data_bits-5){1'b0}}, status_in};   // raw pin levels
      default:
        bus.rdata = '0;
    endcase
  end

endmodule

//--- src/conditioning_mux.sv
/*
  builds the 29 bit conditioning vector from the mode register
  holds the free running test pattern counter
  output is combinational from the registers, so a write shows the next cycle
*/

module conditioning_mux
  import dmm_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      reg_led,
  input  mode_t     reg_mode,
  input  cond_vec_t reg_direct,
  output cond_vec_t cond
);

  ////////////////////
  // test pattern

  cond_vec_t pattern_q;   // wraps at 2^29

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      pattern_q <= '0;
    else
      pattern_q <= pattern_q + 1'b1;   // runs in every mode
  end

  ////////////////////
  // mode select

  always_comb
  begin
    cond = '0;   // codes 4..7 park all switches low
    case (reg_mode)
      mode_led:
        cond[idx_led0] = reg_led;      // mcu blinks the led, rest off
      mode_ones:
        cond = '1;
      mode_pattern:
        cond = pattern_q;              // exercises every pin, handy on a scope
      mode_direct:
        cond = reg_direct;
      default:
        cond = '0;
    endcase
  end

endmodule

//--- src/dmm_top.sv
/*
  meter control FPGA top level, board pins in and out
  spi_cs frames go to the register slave, spi_cs2 routes the pins to the 4094 chain
  the conditioning vector is unpacked here onto the analog switch pins
*/

module dmm_top
  import dmm_pkg::*;
#(
  parameter int sync_stages = 2    // spi pin synchroniser depth
)
(
  input  logic       clk,
  input  logic       rst_n,

  // mcu spi
  input  logic       spi_clk,
  input  logic       spi_cs,
  input  logic       spi_cs2,      // low selects the 4094 chain
  input  logic       spi_mosi,
  output logic       spi_miso,

  // 4094 chain
  input  logic       u1004_4094_data,   // chain serial out
  output logic       oe_4094_ctl,
  output logic       glb_4094_clk,
  output logic       glb_4094_data,
  output logic       glb_4094_strobe_ctl,

  // sense inputs
  input  logic       line_sense_out,    // line sync, not part of the status word
  input  logic       switch_sense_out,
  input  logic       dcv_ovp_out,
  input  logic       ohms_ovp_out,
  input  logic       supply_sense_out,
  input  logic       unused_2_out,

  // conditioning pins
  output logic [3:0] azmux_ctl,      // u414
  output logic [3:0] himux_ctl,      // u413
  output logic [3:0] himux2_ctl,     // u402
  output logic       sig_pc_sw_ctl,
  output logic       led0,
  output logic [7:0] monitor,
  output logic [3:0] adcmux_ctl,     // u902
  output logic       cmpr_latch_ctl,
  output logic       meas_complete_ctl,
  output logic       spi_interupt_ctl
);

  reg_bus_if bus ();

  logic      slave_sdo;
  logic      reg_led;
  mode_t     reg_mode;
  cond_vec_t reg_direct;
  cond_vec_t cond;

  ////////////////////
  // register path

  spi_slave #(
    .sync_stages (sync_stages)
  ) u_spi_slave (
    .clk      (clk),
    .rst_n    (rst_n),
    .spi_clk  (spi_clk),
    .spi_cs   (spi_cs),
    .spi_mosi (spi_mosi),
    .sdo      (slave_sdo),
    .bus      (bus.master)
  );

  register_bank u_register_bank (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus         (bus.slave),
    .status_in   ({switch_sense_out, dcv_ovp_out, ohms_ovp_out,
                   supply_sense_out, unused_2_out}),
    .reg_led     (reg_led),
    .reg_mode    (reg_mode),
    .reg_direct  (reg_direct),
    .oe_4094_ctl (oe_4094_ctl)
  );

  conditioning_mux u_conditioning_mux (
    .clk        (clk),
    .rst_n      (rst_n),
    .reg_led    (reg_led),
    .reg_mode   (reg_mode),
    .reg_direct (reg_direct),
    .cond       (cond)
  );

  ////////////////////
  // 4094 routing, purely combinational

  wire sel_4094 = ~spi_cs2;

  assign glb_4094_clk        = sel_4094 & spi_clk;    // held low when not selected
  assign glb_4094_data       = sel_4094 & spi_mosi;
  assign glb_4094_strobe_ctl = sel_4094 ? strobe_active_high : ~strobe_active_high;
  assign spi_miso            = sel_4094 ? u1004_4094_data : slave_sdo;

  ////////////////////
  // conditioning vector onto pins

  assign azmux_ctl         = cond[idx_azmux +: 4];
  assign himux_ctl         = cond[idx_himux +: 4];
  assign himux2_ctl        = cond[idx_himux2 +: 4];
  assign sig_pc_sw_ctl     = cond[idx_sig_pc_sw];
  assign led0              = cond[idx_led0];
  assign monitor           = cond[idx_monitor +: 8];   // 14..21
  assign adcmux_ctl        = cond[idx_adcmux +: 4];
  assign cmpr_latch_ctl    = cond[idx_cmpr_latch];
  assign meas_complete_ctl = cond[idx_meas_complete];
  assign spi_interupt_ctl  = cond[idx_spi_interupt];

endmodule

//--- verification/dmm_top_sva.sv
/*
  concurrent assertions on the meter control top level, bound into dmm_top
  conditioning pins against the mode rules, 4094 pass-through while spi_cs2 is low
*/

module dmm_top_sva
  import dmm_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic       spi_clk,
  input logic       spi_cs2,
  input logic       spi_mosi,
  input logic       spi_miso,
  input logic       u1004_4094_data,
  input logic       glb_4094_clk,
  input logic       glb_4094_data,
  input logic       glb_4094_strobe_ctl,
  input logic [2:0] mode,      // mode register out of the bank
  input logic       led_bit,
  input cond_vec_t  direct,
  input cond_vec_t  pins       // every conditioning pin, packed by bit index
);

  int unsigned fail_cnt = 0;   // polled by the testbench

  ////////////////////
  // mode rules

  a_mode_led: assert property (@(posedge clk) disable iff (!rst_n)
    mode == mode_led |-> pins == (cond_vec_t'(led_bit) << idx_led0))
    else begin fail_cnt++; $error("led mode drives more than led0"); end

  a_mode_ones: assert property (@(posedge clk) disable iff (!rst_n)
    mode == mode_ones |-> pins == {cond_bits{1'b1}})
    else begin fail_cnt++; $error("ones mode has a low pin"); end

  a_mode_direct: assert property (@(posedge clk) disable iff (!rst_n)
    mode == mode_direct |-> pins == direct)
    else begin fail_cnt++; $error("direct mode pins differ from the register"); end

  // codes 4..7 park everything
  a_mode_off: assert property (@(posedge clk) disable iff (!rst_n)
    mode >= 3'd4 |-> pins == '0)
    else begin fail_cnt++; $error("unnamed mode code left a pin high"); end

  // counter steps by one per clk, wraps at 2^29
  a_pattern_step: assert property (@(posedge clk) disable iff (!rst_n)
    (mode == mode_pattern && $past(mode) == mode_pattern) |-> pins == $past(pins) + 29'd1)
    else begin fail_cnt++; $error("pattern did not advance by one"); end

  ////////////////////
  // 4094 routing

  a_chain_on: assert property (@(posedge clk) disable iff (!rst_n)
    !spi_cs2 |-> (glb_4094_clk == spi_clk && glb_4094_data == spi_mosi
                  && glb_4094_strobe_ctl == strobe_active_high
                  && spi_miso == u1004_4094_data))
    else begin fail_cnt++; $error("4094 chain not passed through"); end

  a_chain_off: assert property (@(posedge clk) disable iff (!rst_n)
    spi_cs2 |-> (!glb_4094_clk && !glb_4094_data
                 && glb_4094_strobe_ctl == !strobe_active_high))
    else begin fail_cnt++; $error("4094 pins active while deselected"); end

endmodule

bind dmm_top dmm_top_sva u_dmm_top_sva (
  .clk                 (clk),
  .rst_n               (rst_n),
  .spi_clk             (spi_clk),
  .spi_cs2             (spi_cs2),
  .spi_mosi            (spi_mosi),
  .spi_miso            (spi_miso),
  .u1004_4094_data     (u1004_4094_data),
  .glb_4094_clk        (glb_4094_clk),
  .glb_4094_data       (glb_4094_data),
  .glb_4094_strobe_ctl (glb_4094_strobe_ctl),
  .mode                (reg_mode),      // bank output
  .led_bit             (reg_led),
  .direct              (reg_direct),
  .pins                ({spi_interupt_ctl, meas_complete_ctl, cmpr_latch_ctl, adcmux_ctl,
                         monitor, led0, sig_pc_sw_ctl, himux2_ctl, himux_ctl, azmux_ctl})
);

//--- verification/tb_dmm_top.sv
/*
  testbench for the meter control FPGA top level
  runs SPI register frames and 4094 pass-through traffic and checks register readback
  pin behaviour per mode is covered by the bound dmm_top_sva assertions
*/

module tb_dmm_top
  import dmm_pkg::*;
;

  localparam int clk_period = 10;
  localparam int spi_phase  = 8;        // clk cycles per spi_clk half period
  localparam int frame_bits = cmd_bits + data_bits;
  localparam int timeout    = (40 * 800 + 2000) * clk_period;   // 40 frames of 800 clk

  logic clk;
  logic rst_n;
  logic spi_clk;
  logic spi_cs;
  logic spi_cs2;
  logic spi_mosi;
  logic spi_miso;
  logic u1004_4094_data;
  logic line_sense_out;
  logic switch_sense_out;
  logic dcv_ovp_out;
  logic ohms_ovp_out;
  logic supply_sense_out;
  logic unused_2_out;
  logic oe_4094_ctl;
  logic glb_4094_clk;
  logic glb_4094_data;
  logic glb_4094_strobe_ctl;
  logic [3:0] azmux_ctl;
  logic [3:0] himux_ctl;
  logic [3:0] himux2_ctl;
  logic [3:0] adcmux_ctl;
  logic sig_pc_sw_ctl;
  logic led0;
  logic [7:0] monitor;
  logic cmpr_latch_ctl;
  logic meas_complete_ctl;
  logic spi_interupt_ctl;

  cond_vec_t pins;   // packed by the vector bit indices
  assign pins = {spi_interupt_ctl, meas_complete_ctl, cmpr_latch_ctl, adcmux_ctl,
                 monitor, led0, sig_pc_sw_ctl, himux2_ctl, himux_ctl, azmux_ctl};

  dmm_top #(.sync_stages(2)) u_dmm_top (.*);

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  ////////////////////
  // helpers

  task automatic stop_on_failure();
    $display("Some tests failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input reg_word_t expected,
                             input reg_word_t actual);
    if (actual !== expected)
    begin
      $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, expected, actual);
      stop_on_failure();
    end
  endtask

  // inputs change 1 unit after the rising edge
  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // mode 0 frame msb first with miso captured at each rising spi_clk after the command byte
  task automatic spi_xfer(input logic rd_flag, input reg_addr_t addr, input reg_word_t wdata,
                          input int nbits, output reg_word_t rdata);
    logic [frame_bits-1:0] frame;
    frame  = {rd_flag, addr, wdata};
    rdata  = '0;
    spi_cs = 1'b0;
    wait_clks(spi_phase);
    for (int i = 0; i < nbits; i++)
    begin
      spi_clk  = 1'b0;                       // slave shifts out here
      spi_mosi = frame[frame_bits-1-i];
      wait_clks(spi_phase);
      spi_clk = 1'b1;                        // slave samples mosi
      if (i >= cmd_bits)
        rdata = {rdata[data_bits-2:0], spi_miso};
      wait_clks(spi_phase);
    end
    spi_clk = 1'b0;
    wait_clks(spi_phase);
    spi_cs = 1'b1;                           // write commits shortly after this
    wait_clks(spi_phase);
  endtask

  task automatic spi_write(input reg_addr_t addr, input reg_word_t wdata);
    reg_word_t ignored;
    spi_xfer(1'b0, addr, wdata, frame_bits, ignored);
  endtask

  task automatic spi_read(input reg_addr_t addr, output reg_word_t rdata);
    spi_xfer(1'b1, addr, '0, frame_bits, rdata);
  endtask

  task automatic read_check(input string name, input reg_addr_t addr,
                            input reg_word_t expected);
    reg_word_t got;
    spi_read(addr, got);
    check_value(name, expected, got);
  endtask

  // clocks random bits through the 4094 route with spi_cs2 low
  task automatic spi_4094_shift(input int nbits);
    logic [31:0] rnd;
    spi_cs2 = 1'b0;
    wait_clks(spi_phase);
    for (int i = 0; i < nbits; i++)
    begin
      rnd             = $urandom();
      spi_clk         = 1'b0;
      spi_mosi        = rnd[0];
      u1004_4094_data = rnd[1];   // chain tail that should appear on miso
      wait_clks(spi_phase);
      spi_clk = 1'b1;
      wait_clks(spi_phase);
    end
    spi_clk = 1'b0;
    wait_clks(spi_phase);
    spi_cs2  = 1'b1;
    spi_mosi = 1'b0;
    wait_clks(spi_phase);
  endtask

  ////////////////////
  // test sequence

  initial
  begin
    reg_word_t  rnd;
    reg_word_t  direct_a;
    logic [4:0] sense;

    rnd = $urandom(96316);   // one seed for the whole run
    rst_n = 1'b0;
    spi_clk = 1'b0;
    spi_cs = 1'b1;
    spi_cs2 = 1'b1;
    spi_mosi = 1'b0;
    u1004_4094_data = 1'b0;
    line_sense_out = 1'b0;
    {switch_sense_out, dcv_ovp_out, ohms_ovp_out, supply_sense_out, unused_2_out} = 5'b0;
    wait_clks(3);
    rst_n = 1'b1;
    wait_clks(2);

    // everything idle and zero out of reset
    check_value("reset pins", '0, reg_word_t'(pins));
    check_value("reset oe", '0, reg_word_t'(oe_4094_ctl));
    for (int a = 0; a <= 4; a++)
      read_check("reset readback", reg_addr_t'(a), '0);

    rnd = $urandom() | 32'h1;   // led on for the led mode later
    spi_write(addr_led, rnd);
    read_check("led readback", addr_led, 32'h1);
    spi_write(addr_oe_4094, 32'hffff_ffff);
    read_check("oe readback", addr_oe_4094, 32'h1);
    check_value("oe pin", 32'h1, reg_word_t'(oe_4094_ctl));
    repeat (2)
    begin
      rnd = $urandom();
      spi_write(addr_direct, rnd);
      read_check("direct readback", addr_direct, rnd & 32'h1fff_ffff);
    end
    spi_write(addr_mode, 32'hffff_fff9);   // low three bits give mode_ones
    read_check("mode readback", addr_mode, 32'h1);

    // status bits 4..0 hold switch dcv ovp ohms ovp supply unused_2 in that order
    // one sense input high at a time so any swap of positions shows
    for (int b = 0; b < 5; b++)
    begin
      rnd   = $urandom();
      sense = 5'b1 << b;
      {switch_sense_out, dcv_ovp_out, ohms_ovp_out, supply_sense_out, unused_2_out} = sense;
      line_sense_out = rnd[5];
      read_check("status readback", addr_status, {27'b0, sense});
    end
    spi_write(7'd9, 32'hffff_ffff);
    read_check("unmapped readback", 7'd9, '0);

    spi_write(addr_mode, 32'h3);           // direct field onto the pins
    wait_clks(20);
    spi_write(addr_mode, 32'h5);
    read_check("mode 5 readback", addr_mode, 32'h5);
    spi_write(addr_mode, 32'h0);           // led0 alone
    wait_clks(20);
    spi_write(addr_mode, 32'h2);           // counter runs on the pins
    wait_clks(200);

    spi_4094_shift(32);

    // frame cut at 20 bits must not land
    direct_a = $urandom();
    spi_write(addr_direct, direct_a);
    spi_xfer(1'b0, addr_direct, ~direct_a, 20, rnd);
    read_check("short frame", addr_direct, direct_a & 32'h1fff_ffff);

    wait_clks(4);
    if (u_dmm_top.u_dmm_top_sva.fail_cnt != 0)
    begin
      $display("an assertion in dmm_top_sva failed");
      stop_on_failure();
    end
    else
    begin
      $display("All tests passed");
      $finish;
    end
  end

  // assertion failures end the run at the next edge
  always @(posedge clk)
  begin
    if (u_dmm_top.u_dmm_top_sva.fail_cnt != 0)
    begin
      $display("an assertion in dmm_top_sva failed");
      stop_on_failure();
    end
  end

  initial
  begin
    #(timeout);
    $display("watchdog expired before the test sequence finished");
    stop_on_failure();
  end

endmodule

//--- compile.f
src/dmm_pkg.sv
src/reg_bus_if.sv
src/spi_slave.sv
src/register_bank.sv
src/conditioning_mux.sv
src/dmm_top.sv
verification/dmm_top_sva.sv
verification/tb_dmm_top.sv

//--- Makefile
# verilator build and run of the meter control testbench

VERILATOR ?= verilator
TOP       ?= tb_dmm_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
